//--- project.f
+incdir+verilog
verilog/ladybird_config.sv
verilog/ladybird_bus.sv
verilog/ladybird_fetch.sv
verilog/ladybird_inst_ram.sv
verilog/ladybird_decode.sv
verilog/ladybird_frontend.sv
testbench/ladybird_frontend_tb.sv

//--- run_sim.sh
#!/bin/sh
# distributed ram build first, then block ram
cd "$(dirname "$0")" || exit 1
for ram in 1 0; do
  verilator --binary --timing --assert -Wno-fatal -f project.f \
    --top-module ladybird_frontend_tb -GDISTRIBUTED_RAM=$ram \
    --Mdir build_ram$ram -o sim \
    && ./build_ram$ram/sim \
    || exit 1
done

//--- testbench/frontend_cases.txt
// op addr_or_pc strb_or_kind data_or_rd rs1 imm
// op 0 end, 1 host write, 2 release reset, 3 expected output, 4 random out_ready on/off
4 0 0 0 0 0
1 fffffff8 f 123455ff 0 0
2 0 0 0 0 0
3 00000000 0 01 00 e0000000
3 00000004 0 02 00 f0000000
3 00000008 1 0a 01 00000006
3 0000000c 3 0a 0a ffffffff
3 00000010 2 00 01 00000000
3 00000014 2 05 01 00000005
3 00000018 1 03 01 0000000b
3 0000001c 2 00 02 00000000
3 00000020 3 0a 00 ffffffff
3 00000024 2 05 01 00000005
3 00000028 4 00 1f ffffffcc
1 00000008 f 123453b7 0 0
1 00000018 8 80aaaaaa 0 0
4 1 0 0 0 0
3 fffffff4 5 00 00 00000000
3 fffffff8 6 0b 08 00000000
3 fffffffc 5 00 00 00000000
3 00000000 0 01 00 e0000000
3 00000004 0 02 00 f0000000
3 00000008 0 07 08 12345000
3 0000000c 3 0a 0a ffffffff
3 00000010 2 00 01 00000000
3 00000014 2 05 01 00000005
3 00000018 1 03 01 fffff80b
3 0000001c 2 00 02 00000000
3 00000020 3 0a 00 ffffffff
3 00000024 2 05 01 00000005
3 00000028 4 00 1f ffffffcc
3 fffffff4 5 00 00 00000000
3 fffffff8 6 0b 08 00000000
0 0 0 0 0 0

//--- testbench/ladybird_frontend_tb.sv
`timescale 1ns/1ps

module ladybird_frontend_tb;
  import ladybird_config::*;

  parameter bit DISTRIBUTED_RAM = 1'b1;

  localparam int FIELDS = 6; // op and five arguments per record
  localparam int MAX_RECS = 64;
  localparam int TIMEOUT = 200;
  localparam int RESET_CYCLES = 16;

  localparam logic [31:0] OP_END = 32'd0;
  localparam logic [31:0] OP_WRITE = 32'd1;
  localparam logic [31:0] OP_RELEASE = 32'd2;
  localparam logic [31:0] OP_EXPECT = 32'd3;
  localparam logic [31:0] OP_STRESS = 32'd4;

  logic clk;
  logic nrst;
  logic host_we;
  logic [31:0] host_addr;
  logic [3:0] host_wstrb;
  logic [31:0] host_wdata;
  logic out_valid;
  logic [31:0] out_pc;
  ladybird_config::inst_kind_t out_kind;
  logic [4:0] out_rd;
  logic [4:0] out_rs1;
  logic [4:0] out_rs2;
  logic [31:0] out_imm;
  logic out_ready;

  logic [31:0] cases [MAX_RECS*FIELDS];
  bit stress; // random out_ready
  int n_checked;
  int n_pre;
  int seed_draw;

  ladybird_frontend #(
    .DISTRIBUTED_RAM (DISTRIBUTED_RAM)
  ) i_ladybird_frontend (
    .clk        (clk),
    .nrst       (nrst),
    .host_we    (host_we),
    .host_addr  (host_addr),
    .host_wstrb (host_wstrb),
    .host_wdata (host_wdata),
    .out_valid  (out_valid),
    .out_pc     (out_pc),
    .out_kind   (out_kind),
    .out_rd     (out_rd),
    .out_rs1    (out_rs1),
    .out_rs2    (out_rs2),
    .out_imm    (out_imm),
    .out_ready  (out_ready)
  );

  always #4 clk = ~clk;

  task automatic fail_run(input string why);
    $display(">>> FAIL");
    $fatal(1, "%s", why);
  endtask

  task automatic check_equal(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got %h, expected %h (output %0d)", name, got, exp, n_checked);
      fail_run("decoded stream differs from the case file");
    end
  endtask

  // rs2 bits sit inside the immediate in every format but S
  function automatic bit rs2_from_imm(input logic [2:0] kind, input logic [31:0] imm,
                                      output logic [31:0] rs2);
    rs2 = '0;
    case (kind)
      KIND_LUI: rs2[4:0] = imm[24:20];
      KIND_JAL: rs2[4:0] = {imm[4:1], imm[11]};
      KIND_LB, KIND_XORI, KIND_NOP: rs2[4:0] = imm[4:0];
      default: return 1'b0; // stores and illegal words carry it apart
    endcase
    return 1'b1;
  endfunction

  // accepted at the next edge, wins over a fetch read
  task automatic host_write(input logic [31:0] addr, input logic [3:0] strb,
                            input logic [31:0] data);
    host_we = 1'b1;
    host_addr = addr;
    host_wstrb = strb;
    host_wdata = data;
    @(posedge clk);
    #1;
    host_we = 1'b0;
    host_wstrb = 4'h0;
  endtask

  // outputs are registered, so they are settled 1 ns after the edge
  task automatic take_output(output logic [31:0] pc, output logic [31:0] kind,
                             output logic [31:0] rd, output logic [31:0] rs1,
                             output logic [31:0] rs2, output logic [31:0] imm);
    int waited;
    bit taken;
    waited = 0;
    taken = 1'b0;
    while (!taken) begin
      if (waited == TIMEOUT) begin
        fail_run($sformatf("no output arrived within %0d cycles", TIMEOUT));
      end
      out_ready = stress ? (($urandom % 100) >= 30) : 1'b1;
      taken = out_valid && out_ready;
      if (taken) begin
        pc = out_pc;
        kind = 32'(out_kind);
        rd = 32'(out_rd);
        rs1 = 32'(out_rs1);
        rs2 = 32'(out_rs2);
        imm = out_imm;
      end
      @(posedge clk);
      #1;
      waited++;
    end
    out_ready = 1'b0; // nothing leaves unchecked
  endtask

  // writes before release go into the last reset cycles, after the image load
  function automatic int writes_before_release();
    int n;
    n = 0;
    for (int i = 0; i < MAX_RECS; i++) begin
      if (cases[i*FIELDS] === OP_RELEASE) break;
      if (cases[i*FIELDS] === OP_WRITE) n++;
    end
    return n;
  endfunction

  task automatic play_cases();
    int rec;
    int base;
    bit done;
    bit rs2_known;
    logic [31:0] pc;
    logic [31:0] kind;
    logic [31:0] rd;
    logic [31:0] rs1;
    logic [31:0] rs2;
    logic [31:0] imm;
    logic [31:0] exp_rs2;
    rec = 0;
    done = 1'b0;
    while (!done && rec < MAX_RECS) begin
      base = rec * FIELDS;
      case (cases[base])
        OP_END: done = 1'b1;
        OP_WRITE: host_write(cases[base+1], cases[base+2][3:0], cases[base+3]);
        OP_RELEASE: nrst = 1'b1;
        OP_STRESS: stress = cases[base+1][0];
        OP_EXPECT: begin
          take_output(pc, kind, rd, rs1, rs2, imm);
          check_equal("out_pc", pc, cases[base+1]);
          check_equal("out_kind", kind, cases[base+2]);
          check_equal("out_rd", rd, cases[base+3]);
          check_equal("out_rs1", rs1, cases[base+4]);
          check_equal("out_imm", imm, cases[base+5]);
          rs2_known = rs2_from_imm(cases[base+2][2:0], cases[base+5], exp_rs2);
          if (rs2_known) begin
            check_equal("out_rs2", rs2, exp_rs2);
          end
          n_checked++;
        end
        default: fail_run($sformatf("case record %0d has an unknown opcode", rec));
      endcase
      rec++;
    end
    if (!done) begin
      fail_run("case file ended without an end record");
    end
  endtask

  initial begin
    clk = 1'b0;
    nrst = 1'b0;
    host_we = 1'b0;
    host_addr = '0;
    host_wstrb = 4'h0;
    host_wdata = '0;
    out_ready = 1'b0;
    stress = 1'b0;
    n_checked = 0;
    seed_draw = $urandom(32'haa61736d);
    $readmemh("testbench/frontend_cases.txt", cases);
    n_pre = writes_before_release();
    if (n_pre >= RESET_CYCLES) begin
      fail_run("too many host writes before reset release");
    end
    repeat (RESET_CYCLES - n_pre) @(posedge clk);
    #1;
    play_cases();
    $display("%0d outputs matched", n_checked);
    $display(">>> PASS");
    $finish;
  end

endmodule

//--- verilog/ladybird_bus.sv
`timescale 1ns/1ps

interface ladybird_bus;
  import ladybird_config::*;

  logic req;
  logic [XLEN-1:0] addr; // byte address
  logic [3:0] wstrb; // all zero means read
  logic [XLEN-1:0] wdata;
  logic gnt;
  logic data_gnt; // read data valid
  logic [XLEN-1:0] rdata;

  modport primary (
    output req,
    output addr,
    output wstrb,
    output wdata,
    input  gnt,
    input  data_gnt,
    input  rdata
  );

  modport secondary (
    input  req,
    input  addr,
    input  wstrb,
    input  wdata,
    output gnt,
    output data_gnt,
    output rdata
  );

endinterface

//--- verilog/ladybird_config.sv
`include "ladybird_macros.svh"

package ladybird_config;

  localparam int XLEN = `LADYBIRD_XLEN;
  localparam int BOOT_WORDS = 2 ** `LADYBIRD_DIST_ADDR_W;

  localparam logic [6:0] OPC_LUI = 7'b0110111;
  localparam logic [6:0] OPC_LOAD = 7'b0000011;
  localparam logic [6:0] OPC_STORE = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_JAL = 7'b1101111;

  localparam logic [2:0] F3_BYTE = 3'b000;
  localparam logic [2:0] F3_ADD = 3'b000;
  localparam logic [2:0] F3_XOR = 3'b100;

  typedef enum logic [2:0] {
    KIND_LUI,
    KIND_LB,
    KIND_SB,
    KIND_XORI,
    KIND_JAL,
    KIND_NOP,
    KIND_ILLEGAL
  } inst_kind_t;

  typedef struct packed {
    inst_kind_t kind;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [XLEN-1:0] imm; // sign extended
  } decoded_t;

  typedef logic [BOOT_WORDS-1:0][XLEN-1:0] boot_image_t;

  function automatic logic [XLEN-1:0] lui(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, OPC_LUI};
  endfunction

  function automatic logic [XLEN-1:0] lb(input logic [4:0] rd, input logic [11:0] imm,
                                         input logic [4:0] rs1);
    return {imm, rs1, F3_BYTE, rd, OPC_LOAD};
  endfunction

  function automatic logic [XLEN-1:0] sb(input logic [4:0] rs2, input logic [11:0] imm,
                                         input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, F3_BYTE, imm[4:0], OPC_STORE};
  endfunction

  // xori rd, rs1, -1
  function automatic logic [XLEN-1:0] inst_not(input logic [4:0] rd, input logic [4:0] rs1);
    return {12'hfff, rs1, F3_XOR, rd, OPC_OP_IMM};
  endfunction

  function automatic logic [XLEN-1:0] jal(input logic [4:0] rd, input logic [20:0] imm);
    logic [20:0] off;
    off = {imm[20:2], 2'b00}; // no compressed, keep targets word aligned
    return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
  endfunction

  function automatic logic [XLEN-1:0] nop();
    return {12'h000, 5'd0, F3_ADD, 5'd0, OPC_OP_IMM};
  endfunction

  // button to led, keypad to uart loop
  function automatic boot_image_t boot_image();
    boot_image_t img;
    for (int i = 0; i < BOOT_WORDS; i++) begin
      img[i] = nop();
    end
    img[0] = lui(5'd1, 20'he0000);
    img[1] = lui(5'd2, 20'hf0000);
    img[2] = lb(5'd10, 12'd6, 5'd1); // buttons
    img[3] = inst_not(5'd10, 5'd10);
    img[4] = sb(5'd10, 12'd0, 5'd1); // leds
    img[5] = sb(5'd10, 12'd5, 5'd1); // keypad column mask
    img[6] = lb(5'd3, 12'd11, 5'd1); // keypad rows
    img[7] = sb(5'd3, 12'd0, 5'd2); // uart tx
    img[8] = inst_not(5'd10, 5'd0);
    img[9] = sb(5'd10, 12'd5, 5'd1);
    img[10] = jal(5'd0, -21'sh32);
    return img;
  endfunction

endpackage

//--- verilog/ladybird_decode.sv
`timescale 1ns/1ps

module ladybird_decode (
  input  logic clk,
  input  logic nrst,
  input  logic inst_valid,
  input  logic [ladybird_config::XLEN-1:0] inst_word,
  input  logic [ladybird_config::XLEN-1:0] inst_pc,
  output logic inst_ready,
  output logic redirect,
  output logic [ladybird_config::XLEN-1:0] redirect_pc,
  output logic out_valid,
  output logic [ladybird_config::XLEN-1:0] out_pc,
  output ladybird_config::decoded_t out,
  input  logic out_ready
);
  import ladybird_config::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_j;
  decoded_t dec;
  logic take;

  assign opcode = inst_word[6:0];
  assign funct3 = inst_word[14:12];

  assign imm_u = {inst_word[31:12], 12'b0};
  assign imm_i = {{(XLEN-12){inst_word[31]}}, inst_word[31:20]};
  assign imm_s = {{(XLEN-12){inst_word[31]}}, inst_word[31:25], inst_word[11:7]};
  assign imm_j = {{(XLEN-20){inst_word[31]}}, inst_word[19:12], inst_word[20],
                  inst_word[30:21], 1'b0};

  always_comb begin
    dec.rd = inst_word[11:7];
    dec.rs1 = inst_word[19:15];
    dec.rs2 = inst_word[24:20];
    dec.kind = KIND_ILLEGAL;
    dec.imm = '0;
    case (opcode)
      OPC_LUI: begin
        dec.kind = KIND_LUI;
        dec.imm = imm_u;
      end
      OPC_LOAD: begin
        if (funct3 == F3_BYTE) begin
          dec.kind = KIND_LB;
          dec.imm = imm_i;
        end
      end
      OPC_STORE: begin
        if (funct3 == F3_BYTE) begin
          dec.kind = KIND_SB;
          dec.imm = imm_s;
        end
      end
      OPC_OP_IMM: begin
        if (funct3 == F3_XOR) begin
          dec.kind = KIND_XORI;
          dec.imm = imm_i;
        end else if (funct3 == F3_ADD) begin
          dec.kind = KIND_NOP; // any addi
          dec.imm = imm_i;
        end
      end
      OPC_JAL: begin
        dec.kind = KIND_JAL;
        dec.imm = imm_j;
      end
      default: begin
        dec.kind = KIND_ILLEGAL;
      end
    endcase
  end

  assign inst_ready = ~out_valid | out_ready;
  assign take = inst_valid & inst_ready;
  // fetch drops whatever followed the jal
  assign redirect = take & (dec.kind == KIND_JAL);
  assign redirect_pc = inst_pc + dec.imm;

  always_ff @(posedge clk) begin
    if (!nrst) begin
      out_valid <= 1'b0;
    end else if (inst_ready) begin
      out_valid <= inst_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      out <= dec;
      out_pc <= inst_pc;
    end
  end

  a_single_redirect: assert property (@(posedge clk) disable iff (!nrst)
    redirect |=> !redirect);

endmodule

//--- verilog/ladybird_fetch.sv
`timescale 1ns/1ps
`include "ladybird_macros.svh"

module ladybird_fetch (
  input  logic clk,
  input  logic nrst,
  ladybird_bus.primary bus,
  input  logic host_we,
  input  logic [ladybird_config::XLEN-1:0] host_addr,
  input  logic [3:0] host_wstrb,
  input  logic [ladybird_config::XLEN-1:0] host_wdata,
  output logic inst_valid,
  output logic [ladybird_config::XLEN-1:0] inst_word,
  output logic [ladybird_config::XLEN-1:0] inst_pc,
  input  logic inst_ready,
  input  logic redirect,
  input  logic [ladybird_config::XLEN-1:0] redirect_pc
);
  import ladybird_config::*;

  localparam int QDEPTH = `LADYBIRD_MAX_INFLIGHT;
  localparam int CNT_W = $clog2(QDEPTH + 1);
  localparam int PTR_W = (QDEPTH > 1) ? $clog2(QDEPTH) : 1;

  logic [XLEN-1:0] pc;
  logic [XLEN-1:0] rsp_pc; // pc of next live return
  logic [CNT_W-1:0] outstanding;
  logic [CNT_W-1:0] stale;
  logic [CNT_W-1:0] q_count;
  logic [PTR_W-1:0] q_rd;
  logic [PTR_W-1:0] q_wr;
  logic [XLEN-1:0] q_word [QDEPTH];
  logic [XLEN-1:0] q_pc [QDEPTH];
  logic [CNT_W:0] busy;
  logic host_wr;
  logic pop;
  logic issue;
  logic rd_acc;
  logic rsp;
  logic rsp_live;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(QDEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign pop = inst_valid & inst_ready;
  // slot freed by this cycle's pop counts as free
  assign busy = {1'b0, outstanding} + {1'b0, q_count} - (CNT_W + 1)'(pop);
  assign host_wr = host_we & (|host_wstrb);
  assign issue = nrst & ~host_we & ~redirect & (busy < (CNT_W + 1)'(QDEPTH));
  assign rd_acc = issue & bus.gnt;
  assign rsp = bus.data_gnt;
  assign rsp_live = rsp & (stale == '0) & ~redirect;

  assign bus.req = host_wr | issue; // host wins the slot
  assign bus.addr = host_we ? host_addr : pc;
  assign bus.wstrb = host_we ? host_wstrb : 4'b0000;
  assign bus.wdata = host_wdata;

  assign inst_valid = (q_count != '0);
  assign inst_word = q_word[q_rd];
  assign inst_pc = q_pc[q_rd];

  always_ff @(posedge clk) begin
    if (!nrst) begin
      pc <= '0;
      rsp_pc <= '0;
      outstanding <= '0;
      stale <= '0;
      q_count <= '0;
      q_rd <= '0;
      q_wr <= '0;
    end else begin
      outstanding <= outstanding + CNT_W'(rd_acc) - CNT_W'(rsp);
      if (redirect) begin
        pc <= redirect_pc;
        rsp_pc <= redirect_pc;
        stale <= outstanding - CNT_W'(rsp); // everything still in flight
        q_count <= '0;
        q_rd <= '0;
        q_wr <= '0;
      end else begin
        if (rd_acc) begin
          pc <= pc + XLEN'(4);
        end
        if (rsp && stale != '0) begin
          stale <= stale - 1'b1;
        end
        if (rsp_live) begin
          rsp_pc <= rsp_pc + XLEN'(4);
          q_wr <= next_ptr(q_wr);
        end
        if (pop) begin
          q_rd <= next_ptr(q_rd);
        end
        q_count <= q_count + CNT_W'(rsp_live) - CNT_W'(pop);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rsp_live) begin
      q_word[q_wr] <= bus.rdata;
      q_pc[q_wr] <= rsp_pc;
    end
  end

  a_no_orphan_data: assert property (@(posedge clk) disable iff (!nrst)
    bus.data_gnt |-> (outstanding != '0));

endmodule

//--- verilog/ladybird_frontend.sv
`timescale 1ns/1ps

module ladybird_frontend #(
  parameter bit DISTRIBUTED_RAM = 1'b1
) (
  input  logic clk,
  input  logic nrst,
  input  logic host_we,
  input  logic [ladybird_config::XLEN-1:0] host_addr,
  input  logic [3:0] host_wstrb,
  input  logic [ladybird_config::XLEN-1:0] host_wdata,
  output logic out_valid,
  output logic [ladybird_config::XLEN-1:0] out_pc,
  output ladybird_config::inst_kind_t out_kind,
  output logic [4:0] out_rd,
  output logic [4:0] out_rs1,
  output logic [4:0] out_rs2,
  output logic [ladybird_config::XLEN-1:0] out_imm,
  input  logic out_ready
);
  import ladybird_config::*;

  logic inst_valid;
  logic inst_ready;
  logic [XLEN-1:0] inst_word;
  logic [XLEN-1:0] inst_pc;
  logic redirect;
  logic [XLEN-1:0] redirect_pc;
  decoded_t dec_out;

  ladybird_bus i_bus ();

  ladybird_fetch i_fetch (
    .clk         (clk),
    .nrst        (nrst),
    .bus         (i_bus),
    .host_we     (host_we),
    .host_addr   (host_addr),
    .host_wstrb  (host_wstrb),
    .host_wdata  (host_wdata),
    .inst_valid  (inst_valid),
    .inst_word   (inst_word),
    .inst_pc     (inst_pc),
    .inst_ready  (inst_ready),
    .redirect    (redirect),
    .redirect_pc (redirect_pc)
  );

  ladybird_inst_ram #(
    .DISTRIBUTED_RAM (DISTRIBUTED_RAM)
  ) i_inst_ram (
    .clk  (clk),
    .nrst (nrst),
    .bus  (i_bus)
  );

  ladybird_decode i_decode (
    .clk         (clk),
    .nrst        (nrst),
    .inst_valid  (inst_valid),
    .inst_word   (inst_word),
    .inst_pc     (inst_pc),
    .inst_ready  (inst_ready),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .out_valid   (out_valid),
    .out_pc      (out_pc),
    .out         (dec_out),
    .out_ready   (out_ready)
  );

  assign out_kind = dec_out.kind;
  assign out_rd = dec_out.rd;
  assign out_rs1 = dec_out.rs1;
  assign out_rs2 = dec_out.rs2;
  assign out_imm = dec_out.imm;

endmodule

//--- verilog/ladybird_inst_ram.sv
`timescale 1ns/1ps
`include "ladybird_macros.svh"

module ladybird_inst_ram #(
  parameter bit DISTRIBUTED_RAM = 1'b1
) (
  input logic clk,
  input logic nrst,
  ladybird_bus.secondary bus
);
  import ladybird_config::*;

  localparam int ADDR_W = DISTRIBUTED_RAM ? `LADYBIRD_DIST_ADDR_W : `LADYBIRD_BRAM_ADDR_W;
  localparam int DEPTH = 2 ** ADDR_W;
  localparam int LATENCY = DISTRIBUTED_RAM ? 1 : 2; // block ram has an output register
  localparam boot_image_t IMAGE = boot_image();

  logic [XLEN-1:0] mem [DEPTH];
  logic [XLEN-1:0] rd_pipe [LATENCY];
  logic [LATENCY-1:0] vld_pipe;
  logic [ADDR_W-1:0] widx;
  logic acc;
  logic rd_acc;
  logic wr_acc;

  assign bus.gnt = 1'b1; // never stalls
  assign acc = bus.req & bus.gnt;
  assign wr_acc = acc & (|bus.wstrb);
  assign rd_acc = acc & ~(|bus.wstrb);
  assign widx = bus.addr[ADDR_W+1:2];

  assign bus.data_gnt = vld_pipe[LATENCY-1];
  assign bus.rdata = rd_pipe[LATENCY-1];

  // host writes during reset land on top of the image
  always_ff @(posedge clk) begin
    if (!nrst) begin
      for (int i = 0; i < BOOT_WORDS; i++) begin
        mem[i] <= IMAGE[i];
      end
      for (int i = BOOT_WORDS; i < DEPTH; i++) begin
        mem[i] <= nop();
      end
    end
    if (wr_acc) begin
      for (int b = 0; b < 4; b++) begin
        if (bus.wstrb[b]) begin
          mem[widx][8*b +: 8] <= bus.wdata[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!nrst) begin
      vld_pipe <= '0;
    end else begin
      vld_pipe[0] <= rd_acc;
      for (int i = 1; i < LATENCY; i++) begin
        vld_pipe[i] <= vld_pipe[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    rd_pipe[0] <= mem[widx]; // read before write
    for (int i = 1; i < LATENCY; i++) begin
      rd_pipe[i] <= rd_pipe[i-1];
    end
  end

  a_word_aligned: assert property (@(posedge clk) disable iff (!nrst)
    bus.req |-> (bus.addr[1:0] == 2'b00));

endmodule

//--- verilog/ladybird_macros.svh
`ifndef LADYBIRD_MACROS_SVH
`define LADYBIRD_MACROS_SVH

// data and address width
`define LADYBIRD_XLEN 32

// most reads fetch keeps outstanding, return queue included
`define LADYBIRD_MAX_INFLIGHT 2

// word address widths of the two ram builds
`define LADYBIRD_DIST_ADDR_W 4
`define LADYBIRD_BRAM_ADDR_W 8

`endif
